//--- Bender.yml
package:
  name: register_access_stall

sources:
  - verilog/x86_decode_pkg.sv
  - verilog/scoreboard_pkg.sv
  - verilog/operand_decode.sv
  - verilog/scoreboard_table.sv
  - verilog/stall_control.sv
  - verilog/register_access_stall.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/register_access_stall_checker.sv
      - sim/register_access_stall_tb.sv

//--- sim/register_access_stall_checker.sv
module register_access_stall_checker (
    input logic                                clk,
    input logic                                rst_n,
    input logic [scoreboard_pkg::num_regs-1:0] inc_hit,
    input logic [scoreboard_pkg::num_regs-1:0] dec_hit,
    input scoreboard_pkg::count_t              counts [scoreboard_pkg::num_regs],
    input scoreboard_pkg::busy_t               busy
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    for (genvar i = 0; i < scoreboard_pkg::num_regs; i++) begin : per_reg
        // a lone increment must not push a full counter past its limit
        no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
            (inc_hit[i] && !dec_hit[i]) |-> (counts[i] != scoreboard_pkg::count_max))
            else begin
                $error("counter %0d incremented at its maximum count", i);
                fail_count++;
            end

        no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
            (dec_hit[i] && !inc_hit[i]) |-> (counts[i] != '0))
            else begin
                $error("counter %0d decremented at zero", i);
                fail_count++;
            end
    end

    busy_clear_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> (busy == '0))
        else begin
            $error("busy vector not clear in the first cycle after reset");
            fail_count++;
        end
endmodule

bind scoreboard_table register_access_stall_checker checker_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .inc_hit (inc_hit),
    .dec_hit (dec_hit),
    .counts  (counts),
    .busy    (busy)
);

//--- sim/register_access_stall_tb.sv
module register_access_stall_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_tests       = 6;
    localparam int max_test_cycles = 220;
    localparam int timeout_ns      = num_tests * max_test_cycles * 20 + 1000;

    logic                     clk;
    logic                     rst_n;
    logic                     register_size;
    x86_decode_pkg::op_type_e op0_type;
    x86_decode_pkg::op_type_e op1_type;
    scoreboard_pkg::reg_idx_t op0_reg;
    scoreboard_pkg::reg_idx_t op1_reg;
    x86_decode_pkg::modrm_t   mod_rm;
    x86_decode_pkg::sib_t     sib;
    logic                     next_stage_ready;
    logic                     wb_enable;
    scoreboard_pkg::reg_idx_t wb_reg;
    logic [1:0]               wb_size;
    logic                     is_stall;

    int                       error_count = 0;
    int                       tests_done = 0;
    scoreboard_pkg::count_t   ref_counts [scoreboard_pkg::num_regs];
    logic                     exp_stall;
    logic                     exp_issue;
    logic                     exp_dest_valid;
    scoreboard_pkg::reg_idx_t exp_dest;
    scoreboard_pkg::reg_idx_t wb_target;

    tb_clock_gen clock_i (.clk(clk), .rst_n(rst_n));

    register_access_stall dut_i (
        .clk(clk), .rst_n(rst_n), .register_size(register_size),
        .op0_type(op0_type), .op0_reg(op0_reg), .op1_type(op1_type), .op1_reg(op1_reg),
        .mod_rm(mod_rm), .sib(sib), .next_stage_ready(next_stage_ready),
        .wb_enable(wb_enable), .wb_reg(wb_reg), .wb_size(wb_size), .is_stall(is_stall)
    );

    // byte registers 4..7 are the high bytes of registers 0..3
    function automatic scoreboard_pkg::reg_idx_t narrow(scoreboard_pkg::reg_idx_t r, logic wide);
        return (!wide && r >= 4) ? r - 3'd4 : r;
    endfunction

    function automatic logic operand_stalls(x86_decode_pkg::op_type_e t,
                                           scoreboard_pkg::reg_idx_t r);
        if (t == x86_decode_pkg::op_register)
            return ref_counts[narrow(r, register_size)] != 0;
        if (t == x86_decode_pkg::op_memory)
            return ref_counts[r] != 0;
        if (t != x86_decode_pkg::op_modrm)
            return 1'b0;
        if (mod_rm[7:6] == x86_decode_pkg::mod_reg)
            return ref_counts[narrow(mod_rm[2:0], register_size)] != 0;
        if (mod_rm[2:0] == x86_decode_pkg::rm_sib)
            return ref_counts[sib[2:0]] != 0 ||
                   (sib[5:3] != x86_decode_pkg::index_none && ref_counts[sib[5:3]] != 0);
        if (mod_rm[7:6] == 2'd0 && mod_rm[2:0] == x86_decode_pkg::rm_disp32)
            return 1'b0;
        return ref_counts[mod_rm[2:0]] != 0;
    endfunction

    always_comb begin
        exp_stall      = operand_stalls(op0_type, op0_reg) || operand_stalls(op1_type, op1_reg);
        exp_dest_valid = 1'b0;
        exp_dest       = '0;
        if (op0_type == x86_decode_pkg::op_register) begin
            exp_dest_valid = 1'b1;
            exp_dest       = narrow(op0_reg, register_size);
        end else if (op0_type == x86_decode_pkg::op_modrm && mod_rm[7:6] == 2'd3) begin
            exp_dest_valid = 1'b1;
            exp_dest       = narrow(mod_rm[2:0], register_size);
        end
        exp_issue = exp_dest_valid && next_stage_ready && !exp_stall;
        wb_target = narrow(wb_reg, wb_size != x86_decode_pkg::wb_size_byte);
    end

    // reference counters count up on issue and down on writeback
    always @(posedge clk or negedge rst_n) begin
        for (int i = 0; i < scoreboard_pkg::num_regs; i++) begin
            if (!rst_n)
                ref_counts[i] <= '0;
            else if (exp_issue && exp_dest == i && !(wb_enable && wb_target == i))
                ref_counts[i] <= ref_counts[i] + 1'b1;
            else if (wb_enable && wb_target == i && !(exp_issue && exp_dest == i))
                ref_counts[i] <= ref_counts[i] - 1'b1;
        end
    end

    stall_check: assert property (@(posedge clk) disable iff (!rst_n) is_stall == exp_stall)
        else begin
            $display("Mismatch at %0t ns: is_stall is %0b, expected %0b",
                     $time, $sampled(is_stall), $sampled(exp_stall));
            error_count++;
        end

    stall_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(is_stall))
        else begin
            $display("is_stall is unknown at %0t ns", $time);
            error_count++;
        end

    function automatic int total_errors();
        return error_count + dut_i.table_i.checker_i.fail_count;
    endfunction

    task automatic tick(int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic drive_ops(logic wide, x86_decode_pkg::op_type_e t0, scoreboard_pkg::reg_idx_t r0,
                             x86_decode_pkg::op_type_e t1, scoreboard_pkg::reg_idx_t r1,
                             logic ready);
        register_size    = wide;
        op0_type         = t0;
        op0_reg          = r0;
        op1_type         = t1;
        op1_reg          = r1;
        next_stage_ready = ready;
    endtask

    task automatic idle();
        drive_ops(1'b1, x86_decode_pkg::op_none, 3'd0, x86_decode_pkg::op_none, 3'd0, 1'b0);
        wb_enable = 1'b0;
    endtask

    task automatic issue_write(scoreboard_pkg::reg_idx_t r, logic wide);
        drive_ops(wide, x86_decode_pkg::op_register, r, x86_decode_pkg::op_none, 3'd0, 1'b1);
        tick(1);
        idle();
    endtask

    task automatic write_back(scoreboard_pkg::reg_idx_t r, logic [1:0] size);
        wb_enable = 1'b1;
        wb_reg    = r;
        wb_size   = size;
        tick(1);
        wb_enable = 1'b0;
    endtask

    task automatic probe_modrm(x86_decode_pkg::modrm_t m, x86_decode_pkg::sib_t s);
        drive_ops(1'b1, x86_decode_pkg::op_none, 3'd0, x86_decode_pkg::op_modrm, 3'd0, 1'b0);
        mod_rm = m;
        sib    = s;
        tick(1);
    endtask

    // writebacks only target registers with a write in flight
    task automatic random_ops(logic allow_count);
        scoreboard_pkg::reg_idx_t target;
        drive_ops($urandom_range(1), x86_decode_pkg::op_type_e'($urandom_range(6)),
                  $urandom_range(7), x86_decode_pkg::op_type_e'($urandom_range(6)),
                  $urandom_range(7), allow_count && $urandom_range(1));
        mod_rm    = $urandom;
        sib       = $urandom;
        wb_reg    = $urandom_range(7);
        wb_size   = $urandom_range(3);
        target    = narrow(wb_reg, wb_size != x86_decode_pkg::wb_size_byte);
        wb_enable = allow_count && $urandom_range(1) && ref_counts[target] != 0;
    endtask

    task automatic finish_test(string name);
        tests_done++;
        $display("test %0d (%s) finished, failures so far %0d", tests_done, name, total_errors());
    endtask

    initial begin
        void'($urandom(32'he111_2f7a));
        idle();
        mod_rm  = '0;
        sib     = '0;
        wb_reg  = '0;
        wb_size = 2'd2;
        @(posedge rst_n);
        tick(1);

        repeat (40) begin
            random_ops(1'b0);
            tick(1);
        end
        idle();
        finish_test("no stall after reset");

        issue_write(3'd0, 1'b1);
        drive_ops(1'b1, x86_decode_pkg::op_none, 3'd0, x86_decode_pkg::op_register, 3'd0, 1'b0);
        tick(3);
        write_back(3'd0, 2'd2);
        tick(2);
        idle();
        finish_test("read after write");

        issue_write(3'd4, 1'b0);
        drive_ops(1'b1, x86_decode_pkg::op_none, 3'd0, x86_decode_pkg::op_register, 3'd0, 1'b0);
        tick(2);
        write_back(3'd4, x86_decode_pkg::wb_size_byte);
        tick(2);
        idle();
        finish_test("byte aliasing");

        for (int r = 3; r <= 6; r++)
            issue_write(r, 1'b1);
        probe_modrm(8'h04, {2'd0, 3'd4, 3'd3});
        probe_modrm(8'h04, {2'd0, 3'd6, 3'd1});
        probe_modrm(8'h04, {2'd0, 3'd4, 3'd1});
        probe_modrm(8'h05, 8'h00);
        probe_modrm(8'h45, 8'h00);
        probe_modrm(8'hc4, 8'h00);
        probe_modrm(8'hc1, 8'h00);
        // sib index of the first operand
        drive_ops(1'b1, x86_decode_pkg::op_modrm, 3'd0, x86_decode_pkg::op_none, 3'd0, 1'b0);
        mod_rm = 8'h04;
        sib    = {2'd0, 3'd6, 3'd1};
        tick(1);
        drive_ops(1'b1, x86_decode_pkg::op_none, 3'd0, x86_decode_pkg::op_memory, 3'd6, 1'b0);
        tick(1);
        for (int r = 3; r <= 6; r++)
            write_back(r, 2'd2);
        tick(1);
        idle();
        finish_test("modrm and sib");

        // held back by next_stage_ready and then cancelled by a same cycle writeback
        drive_ops(1'b1, x86_decode_pkg::op_register, 3'd7, x86_decode_pkg::op_none, 3'd0, 1'b0);
        tick(3);
        drive_ops(1'b1, x86_decode_pkg::op_none, 3'd0, x86_decode_pkg::op_register, 3'd7, 1'b0);
        tick(1);
        drive_ops(1'b1, x86_decode_pkg::op_register, 3'd2, x86_decode_pkg::op_none, 3'd0, 1'b1);
        write_back(3'd2, 2'd2);
        drive_ops(1'b1, x86_decode_pkg::op_register, 3'd2, x86_decode_pkg::op_none, 3'd0, 1'b1);
        tick(3);
        write_back(3'd2, 2'd2);
        tick(1);
        idle();
        finish_test("write counting");

        repeat (200) begin
            random_ops(1'b1);
            tick(1);
        end
        idle();
        tick(1);
        finish_test("random mix");

        $display("tests run: %0d, failures: %0d", tests_done, total_errors());
        if (total_errors() == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns, the tests did not complete", timeout_ns);
        $display("ERRORS FOUND");
        $finish;
    end
endmodule

//--- sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset released just after the fifth rising edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
    end
endmodule

//--- verilog.f
verilog/x86_decode_pkg.sv
verilog/scoreboard_pkg.sv
verilog/operand_decode.sv
verilog/scoreboard_table.sv
verilog/stall_control.sv
verilog/register_access_stall.sv
sim/tb_clock_gen.sv
sim/register_access_stall_checker.sv
sim/register_access_stall_tb.sv

//--- verilog/operand_decode.sv
module operand_decode (
    input  logic                      register_size,
    input  x86_decode_pkg::op_type_e  op0_type,
    input  scoreboard_pkg::reg_idx_t  op0_reg,
    input  x86_decode_pkg::op_type_e  op1_type,
    input  scoreboard_pkg::reg_idx_t  op1_reg,
    input  x86_decode_pkg::modrm_t    mod_rm,
    input  x86_decode_pkg::sib_t      sib,
    output scoreboard_pkg::reg_idx_t  src0_reg,
    output logic                      src0_valid,
    output scoreboard_pkg::reg_idx_t  src1_reg,
    output logic                      src1_valid,
    output scoreboard_pkg::reg_idx_t  src2_reg,
    output logic                      src2_valid,
    output scoreboard_pkg::reg_idx_t  src3_reg,
    output logic                      src3_valid,
    output scoreboard_pkg::reg_idx_t  dest_reg,
    output logic                      dest_valid
);

    logic [1:0]               mod_field;
    scoreboard_pkg::reg_idx_t rm_field;
    scoreboard_pkg::reg_idx_t sib_base;
    scoreboard_pkg::reg_idx_t sib_index;

    assign mod_field = mod_rm[7:6];
    assign rm_field  = mod_rm[2:0];
    assign sib_base  = sib[2:0];
    assign sib_index = sib[5:3];

    // byte operands: ah, ch, dh, bh live in the upper half of regs 0..3
    function automatic scoreboard_pkg::reg_idx_t size_fix(input scoreboard_pkg::reg_idx_t r);
        if (!register_size && r[2]) begin
            return {1'b0, r[1:0]};
        end
        return r;
    endfunction

    // registers read by one operand: a primary one plus an optional sib index
    function automatic void decode_operand(
        input  x86_decode_pkg::op_type_e op_type,
        input  scoreboard_pkg::reg_idx_t op_reg,
        output scoreboard_pkg::reg_idx_t prim_reg,
        output logic                     prim_valid,
        output scoreboard_pkg::reg_idx_t idx_reg,
        output logic                     idx_valid
    );
        prim_reg   = '0;
        prim_valid = 1'b0;
        idx_reg    = sib_index;
        idx_valid  = 1'b0;
        case (op_type)
            x86_decode_pkg::op_register: begin
                prim_reg   = size_fix(op_reg);
                prim_valid = 1'b1;
            end
            x86_decode_pkg::op_memory: begin
                // address register, always 32 bit
                prim_reg   = op_reg;
                prim_valid = 1'b1;
            end
            x86_decode_pkg::op_modrm: begin
                if (mod_field == x86_decode_pkg::mod_reg) begin
                    prim_reg   = size_fix(rm_field);
                    prim_valid = 1'b1;
                end else if (rm_field == x86_decode_pkg::rm_sib) begin
                    prim_reg   = sib_base;
                    prim_valid = 1'b1;
                    idx_valid  = (sib_index != x86_decode_pkg::index_none);
                end else if (mod_field == x86_decode_pkg::mod_indirect &&
                             rm_field == x86_decode_pkg::rm_disp32) begin
                    // absolute disp32, no register involved
                    prim_valid = 1'b0;
                end else begin
                    prim_reg   = rm_field;
                    prim_valid = 1'b1;
                end
            end
            default: begin
                prim_valid = 1'b0;
            end
        endcase
    endfunction

    always_comb begin
        decode_operand(op0_type, op0_reg, src0_reg, src0_valid, src1_reg, src1_valid);
        decode_operand(op1_type, op1_reg, src2_reg, src2_valid, src3_reg, src3_valid);
    end

    // op0 is the write target when it names a register directly
    always_comb begin
        dest_reg   = '0;
        dest_valid = 1'b0;
        if (op0_type == x86_decode_pkg::op_register) begin
            dest_reg   = size_fix(op0_reg);
            dest_valid = 1'b1;
        end else if (op0_type == x86_decode_pkg::op_modrm &&
                     mod_field == x86_decode_pkg::mod_reg) begin
            dest_reg   = size_fix(rm_field);
            dest_valid = 1'b1;
        end
    end

endmodule

//--- verilog/register_access_stall.sv
module register_access_stall (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     register_size,
    input  x86_decode_pkg::op_type_e op0_type,
    input  scoreboard_pkg::reg_idx_t op0_reg,
    input  x86_decode_pkg::op_type_e op1_type,
    input  scoreboard_pkg::reg_idx_t op1_reg,
    input  x86_decode_pkg::modrm_t   mod_rm,
    input  x86_decode_pkg::sib_t     sib,
    input  logic                     next_stage_ready,
    input  logic                     wb_enable,
    input  scoreboard_pkg::reg_idx_t wb_reg,
    input  logic [1:0]               wb_size,
    output logic                     is_stall
);

    scoreboard_pkg::reg_idx_t src0_reg;
    scoreboard_pkg::reg_idx_t src1_reg;
    scoreboard_pkg::reg_idx_t src2_reg;
    scoreboard_pkg::reg_idx_t src3_reg;
    scoreboard_pkg::reg_idx_t dest_reg;
    logic                     src0_valid;
    logic                     src1_valid;
    logic                     src2_valid;
    logic                     src3_valid;
    logic                     dest_valid;
    logic                     issue;
    scoreboard_pkg::busy_t    busy;

    operand_decode decode_i (
        .register_size (register_size),
        .op0_type      (op0_type),
        .op0_reg       (op0_reg),
        .op1_type      (op1_type),
        .op1_reg       (op1_reg),
        .mod_rm        (mod_rm),
        .sib           (sib),
        .src0_reg      (src0_reg),
        .src0_valid    (src0_valid),
        .src1_reg      (src1_reg),
        .src1_valid    (src1_valid),
        .src2_reg      (src2_reg),
        .src2_valid    (src2_valid),
        .src3_reg      (src3_reg),
        .src3_valid    (src3_valid),
        .dest_reg      (dest_reg),
        .dest_valid    (dest_valid)
    );

    stall_control control_i (
        .src0_reg         (src0_reg),
        .src0_valid       (src0_valid),
        .src1_reg         (src1_reg),
        .src1_valid       (src1_valid),
        .src2_reg         (src2_reg),
        .src2_valid       (src2_valid),
        .src3_reg         (src3_reg),
        .src3_valid       (src3_valid),
        .dest_valid       (dest_valid),
        .next_stage_ready (next_stage_ready),
        .busy             (busy),
        .is_stall         (is_stall),
        .issue            (issue)
    );

    scoreboard_table table_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .dest_reg  (dest_reg),
        .wb_enable (wb_enable),
        .wb_reg    (wb_reg),
        .wb_size   (wb_size),
        .busy      (busy)
    );

endmodule

//--- verilog/scoreboard_pkg.sv
package scoreboard_pkg;

    // general register number, eax..edi
    typedef logic [2:0] reg_idx_t;

    // one counter per general register
    localparam int num_regs = 8;

    // writes in flight to one register
    typedef logic [3:0] count_t;

    // largest legal count, no wrap past it
    localparam count_t count_max = 4'd15;

    // bit n set while register n has a write outstanding
    typedef logic [num_regs-1:0] busy_t;

endpackage

//--- verilog/scoreboard_table.sv
module scoreboard_table (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue,
    input  scoreboard_pkg::reg_idx_t dest_reg,
    input  logic                     wb_enable,
    input  scoreboard_pkg::reg_idx_t wb_reg,
    input  logic [1:0]               wb_size,
    output scoreboard_pkg::busy_t    busy
);

    scoreboard_pkg::count_t                   counts [scoreboard_pkg::num_regs];
    scoreboard_pkg::reg_idx_t                 wb_reg_eff;
    logic [scoreboard_pkg::num_regs-1:0]      inc_hit;
    logic [scoreboard_pkg::num_regs-1:0]      dec_hit;

    // byte writebacks to 4..7 land on the high byte of regs 0..3
    assign wb_reg_eff = (wb_size == x86_decode_pkg::wb_size_byte && wb_reg[2]) ?
                        {1'b0, wb_reg[1:0]} : wb_reg;

    always_comb begin
        for (int i = 0; i < scoreboard_pkg::num_regs; i++) begin
            inc_hit[i] = issue && (dest_reg == scoreboard_pkg::reg_idx_t'(i));
            dec_hit[i] = wb_enable && (wb_reg_eff == scoreboard_pkg::reg_idx_t'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < scoreboard_pkg::num_regs; i++) begin
                counts[i] <= '0;
            end
        end else begin
            for (int i = 0; i < scoreboard_pkg::num_regs; i++) begin
                // issue and writeback on the same register cancel out
                if (inc_hit[i] && !dec_hit[i]) begin
                    counts[i] <= counts[i] + 1'b1;
                end else if (dec_hit[i] && !inc_hit[i]) begin
                    counts[i] <= counts[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < scoreboard_pkg::num_regs; i++) begin
            busy[i] = (counts[i] != '0);
        end
    end

endmodule

//--- verilog/stall_control.sv
module stall_control (
    input  scoreboard_pkg::reg_idx_t src0_reg,
    input  logic                     src0_valid,
    input  scoreboard_pkg::reg_idx_t src1_reg,
    input  logic                     src1_valid,
    input  scoreboard_pkg::reg_idx_t src2_reg,
    input  logic                     src2_valid,
    input  scoreboard_pkg::reg_idx_t src3_reg,
    input  logic                     src3_valid,
    input  logic                     dest_valid,
    input  logic                     next_stage_ready,
    input  scoreboard_pkg::busy_t    busy,
    output logic                     is_stall,
    output logic                     issue
);

    logic [3:0] src_hazard;

    // a source is a hazard only when it is actually read
    assign src_hazard[0] = src0_valid && busy[src0_reg];
    assign src_hazard[1] = src1_valid && busy[src1_reg];
    assign src_hazard[2] = src2_valid && busy[src2_reg];
    assign src_hazard[3] = src3_valid && busy[src3_reg];

    assign is_stall = |src_hazard;

    // count a write only when the instruction really leaves the stage
    assign issue = dest_valid && next_stage_ready && !is_stall;

endmodule

//--- verilog/x86_decode_pkg.sv
package x86_decode_pkg;

    // operand kinds as delivered by the opcode lookup
    typedef enum logic [2:0] {
        op_none        = 3'd0,
        op_register    = 3'd1,
        op_segment     = 3'd2,
        op_mm_register = 3'd3,
        op_modrm       = 3'd4,
        op_immediate   = 3'd5,
        op_memory      = 3'd6
    } op_type_e;

    // raw addressing bytes
    // modrm is {mod[7:6], reg[5:3], rm[2:0]}, sib is {scale[7:6], index[5:3], base[2:0]}
    typedef logic [7:0] modrm_t;
    typedef logic [7:0] sib_t;

    // mod field values
    localparam logic [1:0] mod_indirect = 2'd0;
    localparam logic [1:0] mod_reg = 2'd3;

    // r/m escapes
    localparam logic [2:0] rm_sib = 3'd4;
    localparam logic [2:0] rm_disp32 = 3'd5;

    // sib index 100 means no index register
    localparam logic [2:0] index_none = 3'd4;

    // writeback size code for byte results
    localparam logic [1:0] wb_size_byte = 2'd0;

endpackage
